//--- sources.f
+incdir+verif
src/ddr_geom_pkg.sv
src/ddr_bus_pkg.sv
src/write_phase_tracker.sv
src/dq_write_serializer.sv
src/dqs_strobe_ctrl.sv
src/dq_read_deserializer.sv
src/dqdqs_pad_group.sv
verif/dqdqs_tb.sv

//--- Makefile
# Verilator flow for the DDR3 byte lane testbench

VERILATOR ?= verilator
TOP       ?= dqdqs_tb
RTL_TOP   ?= dqdqs_pad_group
SEED      ?= 80035
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		-Gseed=$(SEED) --Mdir $(OBJ_DIR)

# Verdict comes from the pass line in the output
run: build
	@out=$$(./$(BIN) 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/dqdqs_model.svh
// Cycle model of the byte lane; call model_step once per rising edge with the inputs that edge samples
`ifndef DQDQS_MODEL_SVH
`define DQDQS_MODEL_SVH

// ################################################
// Model state
// ################################################

typedef struct packed
{
    logic      act_r1;
    logic      act_r2;
    hr_phase_e phase;
} trk_state_t;

trk_state_t  m_wr_trk;     // DQ half select
trk_state_t  m_dqs_trk;    // DQS half select
wr_fr_out_t  m_wr_r;       // Before pad sleep
logic        m_dqs_os;
logic        m_dqs_r;      // Before pad sleep
fr_pair_t    m_rd_r;       // Newest captured pair
fr_pair_t    m_rd_r1;
logic        m_cap_phase;
rd_hr_word_t m_rd_word;
logic        m_rd_valid;

// Burst start when activity was seen last edge but not the one before
function automatic trk_state_t trk_next(input trk_state_t s, input logic active);
    trk_state_t n;
    n.act_r1 = active;
    n.act_r2 = s.act_r1;
    if (s.act_r1 && !s.act_r2)
        n.phase = PHASE_FIRST;
    else if (s.phase == PHASE_FIRST)
        n.phase = PHASE_SECOND;
    else
        n.phase = PHASE_FIRST;
    return n;
endfunction

task automatic model_reset();
    m_wr_trk.act_r1  = 1'b0;
    m_wr_trk.act_r2  = 1'b0;
    m_wr_trk.phase   = PHASE_SECOND;
    m_dqs_trk        = m_wr_trk;
    m_wr_r           = '0;
    m_dqs_os         = 1'b0;
    m_dqs_r          = 1'b0;
    m_rd_r           = '0;
    m_rd_r1          = '0;
    m_cap_phase      = 1'b0;
    m_rd_word        = '0;
    m_rd_valid       = 1'b0;
endtask

task automatic model_step(input wr_hr_word_t w, input logic [oe_halves-1:0] ena,
                          input fr_pair_t rp, input logic inv);
    wr_fr_out_t wr_d;
    logic       dqs_d;
    logic       load;
    // Write side uses the phase valid before this edge
    if (m_wr_trk.phase == PHASE_FIRST)
    begin
        wr_d.pair.rise = w.beat[0];
        wr_d.pair.fall = w.beat[1];
        wr_d.oe        = w.oe[0];
    end
    else
    begin
        wr_d.pair.rise = w.beat[2];
        wr_d.pair.fall = w.beat[3];
        wr_d.oe        = w.oe[1];
    end
    dqs_d = (m_dqs_trk.phase == PHASE_FIRST) ? ena[0] : ena[1];

    // Read packing, older pair fills beats 0 and 1
    load = (m_cap_phase != inv);
    if (load)
    begin
        m_rd_word.beat[0] = m_rd_r1.rise;
        m_rd_word.beat[1] = m_rd_r1.fall;
        m_rd_word.beat[2] = m_rd_r.rise;
        m_rd_word.beat[3] = m_rd_r.fall;
    end
    m_rd_valid  = load;
    m_cap_phase = ~m_cap_phase;
    m_rd_r1     = m_rd_r;
    m_rd_r      = rp;

    m_dqs_r   = m_dqs_os;  // Extra strobe stage
    m_dqs_os  = dqs_d;
    m_wr_r    = wr_d;
    m_wr_trk  = trk_next(m_wr_trk, |w.oe);
    m_dqs_trk = trk_next(m_dqs_trk, |ena);
endtask

`endif

//--- verif/dqdqs_tb.sv
// Random bursts from a fixed seed; outputs are checked on the falling edge against the included model
`timescale 1ns/100ps

module dqdqs_tb
    import ddr_geom_pkg::*;
    import ddr_bus_pkg::*;
#(
    parameter int unsigned seed = 80035
);

    localparam int n_bursts       = 40;
    localparam int max_gap        = 6;
    localparam int max_words      = 8;
    localparam int reset_cycles   = 2;
    localparam int drain_cycles   = 8;
    // Lead-in word takes two extra cycles per burst
    localparam int planned_cycles = reset_cycles + drain_cycles
                                  + n_bursts * (max_gap + 2 * max_words + 2);
    localparam int cycle_limit    = 2 * planned_cycles + 100;

    logic                 pll_mem_clk;
    logic                 rst_n;
    logic                 mem_clk_enable;
    logic                 invert_hr_clock;
    wr_hr_word_t          wr_word;
    logic [oe_halves-1:0] strobe_ena;
    fr_pair_t             rd_pair;
    wr_fr_out_t           wr_out;
    logic                 dqs_oe;
    rd_hr_word_t          rd_word;
    logic                 rd_word_valid;

    int unsigned cycle_cnt = 0;

    `include "dqdqs_model.svh"

    dqdqs_pad_group UUT
    (
        .pll_mem_clk     (pll_mem_clk),
        .rst_n           (rst_n),
        .mem_clk_enable  (mem_clk_enable),
        .invert_hr_clock (invert_hr_clock),
        .wr_word         (wr_word),
        .strobe_ena      (strobe_ena),
        .wr_out          (wr_out),
        .dqs_oe          (dqs_oe),
        .rd_pair         (rd_pair),
        .rd_word         (rd_word),
        .rd_word_valid   (rd_word_valid)
    );

    always #5 pll_mem_clk = ~pll_mem_clk;

    // ################################################
    // Compare tasks
    // ################################################

    task automatic stop_run(input string why);
        $display("STATUS: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_wr_out(input wr_fr_out_t exp, input wr_fr_out_t act);
        if (act !== exp)
        begin
            $display("ERR %0t wr_out expected %h actual %h", $time, exp, act);
            stop_run("write output differs from model");
        end
    endtask

    task automatic check_dqs_oe(input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %0t dqs_oe expected %b actual %b", $time, exp, act);
            stop_run("strobe enable differs from model");
        end
    endtask

    task automatic check_rd_word(input rd_hr_word_t exp, input logic exp_valid,
                                 input rd_hr_word_t act, input logic act_valid);
        if (act_valid !== exp_valid)
        begin
            $display("ERR %0t rd_word_valid expected %b actual %b", $time, exp_valid, act_valid);
            stop_run("read valid differs from model");
        end
        if (act !== exp)
        begin
            $display("ERR %0t rd_word expected %h actual %h", $time, exp, act);
            stop_run("read word differs from model");
        end
    endtask

    // Outputs are settled mid-cycle; model then advances for the next edge
    always @(negedge pll_mem_clk)
    begin
        if (rst_n)
        begin
            check_wr_out({m_wr_r.pair, m_wr_r.oe & {dq_pins{mem_clk_enable}}}, wr_out);
            check_dqs_oe(m_dqs_r & mem_clk_enable, dqs_oe);
            check_rd_word(m_rd_word, m_rd_valid, rd_word, rd_word_valid);
            model_step(wr_word, strobe_ena, rd_pair, invert_hr_clock);
        end
    end

    always @(posedge pll_mem_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("Timeout, the run went past %0d cycles", cycle_limit);
            stop_run("timeout");
        end
    end

    // ################################################
    // Stimulus
    // ################################################

    function automatic wr_hr_word_t random_word(input logic active);
        wr_hr_word_t w;
        w.beat = $urandom;
        w.oe   = active ? (16'($urandom) | 16'h0101) : 16'h0000;  // Never empty in a burst
        return w;
    endfunction

    task automatic drive_cycle(input wr_hr_word_t w, input logic [oe_halves-1:0] ena,
                               input logic awake, input logic inv);
        @(posedge pll_mem_clk);
        wr_word         <= w;
        strobe_ena      <= ena;
        mem_clk_enable  <= awake;
        invert_hr_clock <= inv;
        rd_pair         <= fr_pair_t'(16'($urandom));  // Read data every cycle
    endtask

    initial
    begin
        int unsigned          gap;
        int unsigned          words;
        int unsigned          hold;
        logic                 awake;
        logic                 inv;
        logic [oe_halves-1:0] ena;
        wr_hr_word_t          w;
        void'($urandom(seed));
        pll_mem_clk     = 1'b0;
        rst_n           = 1'b0;
        mem_clk_enable  = 1'b1;
        invert_hr_clock = 1'b0;
        wr_word         = '0;
        strobe_ena      = '0;
        rd_pair         = '0;
        model_reset();
        awake = 1'b1;
        inv   = 1'b0;

        repeat (reset_cycles) @(posedge pll_mem_clk);
        rst_n <= 1'b1;

        for (int b = 0; b < n_bursts; b++)
        begin
            gap   = 1 + ($urandom % max_gap);
            words = 2 + ($urandom % (max_words - 1));
            awake = ($urandom % 4) != 0;  // Pads asleep now and then
            if ($urandom % 3 == 0)
                inv = ~inv;
            repeat (gap)
                drive_cycle(random_word(1'b0), 2'b00, awake, inv);
            for (int k = 0; k < int'(words); k++)
            begin
                w    = random_word(1'b1);
                ena  = 2'(1 + ($urandom % 3));  // Any non-empty pair of strobe halves
                hold = (k == 0) ? 4 : 2;  // First word covers the lead-in
                repeat (hold)
                    drive_cycle(w, ena, awake, inv);
            end
        end
        repeat (drain_cycles)
            drive_cycle(random_word(1'b0), 2'b00, 1'b1, inv);
        @(posedge pll_mem_clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule : dqdqs_tb

//--- src/dqdqs_pad_group.sv
// Single clock byte lane with pads modelled as rise/fall pairs; paths are independent, no back-pressure anywhere
`timescale 1ns/100ps

module dqdqs_pad_group
    import ddr_geom_pkg::*;
    import ddr_bus_pkg::*;
(
    input  logic                 pll_mem_clk,
    input  logic                 rst_n,
    input  logic                 mem_clk_enable,   // Low puts all pads to sleep
    input  logic                 invert_hr_clock,

    // Write and strobe side
    input  wr_hr_word_t          wr_word,
    input  logic [oe_halves-1:0] strobe_ena,
    output wr_fr_out_t           wr_out,
    output logic                 dqs_oe,

    // Read side
    input  fr_pair_t             rd_pair,
    output rd_hr_word_t          rd_word,
    output logic                 rd_word_valid
);

    // ################################################
    // DQ write path
    // ################################################

    dq_write_serializer u_dq_wr
    (
        .pll_mem_clk    (pll_mem_clk),
        .rst_n          (rst_n),
        .mem_clk_enable (mem_clk_enable),
        .wr_word        (wr_word),
        .wr_out         (wr_out)
    );

    // ################################################
    // DQS enable path
    // ################################################

    dqs_strobe_ctrl u_dqs
    (
        .pll_mem_clk    (pll_mem_clk),
        .rst_n          (rst_n),
        .mem_clk_enable (mem_clk_enable),
        .strobe_ena     (strobe_ena),
        .dqs_oe         (dqs_oe)
    );

    // Read capture, natural word order
    dq_read_deserializer #(
        .reverse_read_words (1'b0)
    ) u_dq_rd
    (
        .pll_mem_clk     (pll_mem_clk),
        .rst_n           (rst_n),
        .invert_hr_clock (invert_hr_clock),
        .rd_pair         (rd_pair),
        .rd_word         (rd_word),
        .rd_word_valid   (rd_word_valid)
    );

endmodule : dqdqs_pad_group

//--- src/dq_read_deserializer.sv
// Capture phase free-runs from reset with no burst alignment; invert_hr_clock is the only way to shift word boundaries
`timescale 1ns/100ps

module dq_read_deserializer
    import ddr_geom_pkg::*;
    import ddr_bus_pkg::*;
#(
    parameter bit reverse_read_words = 1'b0  // Swap rise and fall within each pair
)
(
    input  logic        pll_mem_clk,
    input  logic        rst_n,
    input  logic        invert_hr_clock,  // Level, moves capture by one cycle
    input  fr_pair_t    rd_pair,
    output rd_hr_word_t rd_word,
    output logic        rd_word_valid
);

    // Index 0 holds the earlier beat of the pair
    logic [beats_per_fr-1:0][dq_pins-1:0] pair_ord;
    logic [beats_per_fr-1:0][dq_pins-1:0] rd_r;
    logic [beats_per_fr-1:0][dq_pins-1:0] rd_r1;
    logic                                 cap_phase;
    logic                                 cap_load;

    // Word-order swap
    assign pair_ord[0] = reverse_read_words ? rd_pair.fall : rd_pair.rise;
    assign pair_ord[1] = reverse_read_words ? rd_pair.rise : rd_pair.fall;

    // ################################################
    // Full-rate capture stages
    // ################################################

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_r  <= '0;
            rd_r1 <= '0;
        end
        else
        begin
            rd_r  <= pair_ord;
            rd_r1 <= rd_r;  // Older pair
        end
    end

    // ################################################
    // Half-rate packing
    // ################################################

    // Divide-by-two capture phase
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
            cap_phase <= 1'b0;
        else
            cap_phase <= ~cap_phase;
    end

    assign cap_load = cap_phase ^ invert_hr_clock;

    // Beats 0 and 1 from rd_r1, beats 2 and 3 from rd_r
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_word       <= '0;
            rd_word_valid <= 1'b0;
        end
        else
        begin
            rd_word_valid <= cap_load;
            if (cap_load)
                rd_word <= rd_hr_word_t'({rd_r, rd_r1});
        end
    end

endmodule : dq_read_deserializer

//--- src/dqs_strobe_ctrl.sv
// Only the DQS enable leaves this block; it trails the DQ enable by one cycle, the toggle pattern is external
`timescale 1ns/100ps

module dqs_strobe_ctrl
    import ddr_geom_pkg::*;
    import ddr_bus_pkg::*;
(
    input  logic                 pll_mem_clk,
    input  logic                 rst_n,
    input  logic                 mem_clk_enable,
    input  logic [oe_halves-1:0] strobe_ena,  // Half 0 first
    output logic                 dqs_oe
);

    hr_phase_e phase;
    logic      os_oe;
    logic      os_oe_r;
    logic      dqs_oe_r;

    // Strobe keeps its own alignment, independent of DQ
    write_phase_tracker u_tracker
    (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .active      (|strobe_ena),
        .phase       (phase)
    );

    assign os_oe = (phase == PHASE_FIRST) ? strobe_ena[0] : strobe_ena[1];

    // ################################################
    // Serializer stage plus the extra strobe register
    // ################################################

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            os_oe_r  <= 1'b0;
            dqs_oe_r <= 1'b0;
        end
        else
        begin
            os_oe_r  <= os_oe;
            dqs_oe_r <= os_oe_r;  // Extra cycle for the strobe pad
        end
    end

    assign dqs_oe = dqs_oe_r & mem_clk_enable;  // Sleep forces the strobe off

endmodule : dqs_strobe_ctrl

//--- src/dq_write_serializer.sv
// Source must hold each half-rate word two cycles, aligned so PHASE_FIRST lands two edges after the enables rise
`timescale 1ns/100ps

module dq_write_serializer
    import ddr_geom_pkg::*;
    import ddr_bus_pkg::*;
(
    input  logic        pll_mem_clk,
    input  logic        rst_n,
    input  logic        mem_clk_enable,  // Low puts the pads to sleep
    input  wr_hr_word_t wr_word,
    output wr_fr_out_t  wr_out
);

    hr_phase_e  phase;
    wr_fr_out_t out_d;
    wr_fr_out_t out_r;

    // ################################################
    // Phase tracking
    // ################################################

    write_phase_tracker u_tracker
    (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .active      (|wr_word.oe),
        .phase       (phase)
    );

    // ################################################
    // Half-rate to full-rate mux
    // ################################################

    always_comb
    begin
        if (phase == PHASE_FIRST)
        begin
            out_d.pair.rise = wr_word.beat[0];
            out_d.pair.fall = wr_word.beat[1];
            out_d.oe        = wr_word.oe[0];
        end
        else
        begin
            out_d.pair.rise = wr_word.beat[2];  // Second half of the word
            out_d.pair.fall = wr_word.beat[3];
            out_d.oe        = wr_word.oe[1];
        end
    end

    // Output register in front of the pads
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
            out_r <= '0;
        else
            out_r <= out_d;
    end

    // Pad sleep acts on the enables only, data keeps toggling
    assign wr_out.pair = out_r.pair;
    assign wr_out.oe   = out_r.oe & {dq_pins{mem_clk_enable}};

endmodule : dq_write_serializer

//--- src/write_phase_tracker.sv
// Restarts on a rising edge of active seen one cycle late; with active stuck high it simply alternates
`timescale 1ns/100ps

module write_phase_tracker
    import ddr_bus_pkg::*;
(
    input  logic      pll_mem_clk,
    input  logic      rst_n,
    input  logic      active,  // OR of all enables of the half-rate word
    output hr_phase_e phase
);

    logic act_r1;
    logic act_r2;
    logic burst_start;

    // Activity history, two stages
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            act_r1 <= 1'b0;
            act_r2 <= 1'b0;
        end
        else
        begin
            act_r1 <= active;
            act_r2 <= act_r1;
        end
    end

    assign burst_start = act_r1 & ~act_r2;

    // Half select, realigned at each burst start
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
            phase <= PHASE_SECOND;
        else if (burst_start)
            phase <= PHASE_FIRST;
        else if (phase == PHASE_FIRST)
            phase <= PHASE_SECOND;
        else
            phase <= PHASE_FIRST;
    end

endmodule : write_phase_tracker

//--- src/ddr_bus_pkg.sv
// Bus types for the byte lane; beat 0 is always the oldest beat on the pins, phase enum is one bit
package ddr_bus_pkg;

    import ddr_geom_pkg::*;

    // ################################################
    // Phase select
    // ################################################

    // Which half of a half-rate word is on the pins.
    // PHASE_SECOND encodes as zero so a reset tracker idles there
    typedef enum logic
    {
        PHASE_SECOND = 1'b0,
        PHASE_FIRST  = 1'b1
    } hr_phase_e;

    // ################################################
    // Write side
    // ################################################

    // Half-rate write word, 48 bits
    typedef struct packed
    {
        logic [beats_per_hr-1:0][dq_pins-1:0] beat;  // Beat 0 goes out first
        logic [oe_halves-1:0][dq_pins-1:0]    oe;    // Half 0 covers beats 0 and 1
    } wr_hr_word_t;

    // One full-rate cycle on the pads, used for write and read
    typedef struct packed
    {
        logic [dq_pins-1:0] rise;
        logic [dq_pins-1:0] fall;
    } fr_pair_t;

    typedef struct packed
    {
        fr_pair_t           pair;
        logic [dq_pins-1:0] oe;  // Per-pin output enable
    } wr_fr_out_t;

    // ################################################
    // Read side
    // ################################################

    typedef struct packed
    {
        logic [beats_per_hr-1:0][dq_pins-1:0] beat;  // Beat 0 oldest
    } rd_hr_word_t;

endpackage : ddr_bus_pkg

//--- src/ddr_geom_pkg.sv
// Lane geometry for one x8 DDR3 byte lane at half rate; values are fixed and not overridable per instance
package ddr_geom_pkg;

    // ################################################
    // Pin counts
    // ################################################

    // DQ pins in one byte lane, DQS is handled apart
    localparam int dq_pins = 8;

    // ################################################
    // Rate conversion
    // ################################################

    // One half-rate word carries four beats per pin
    localparam int beats_per_hr = 4;

    localparam int beats_per_fr = 2;  // Rise and fall of one full-rate cycle

    // Output enables come as two halves per word,
    // one for each full-rate cycle of the word
    localparam int oe_halves = 2;

endpackage : ddr_geom_pkg
